//--- aes256_dec.f
+incdir+src
src/aes_types_pkg.sv
src/aes_ctrl_pkg.sv
src/aes_stage_if.sv
src/inv_sbox_rom.sv
src/inv_shift_sub_bytes.sv
src/inv_mix_columns.sv
src/dec_round_ctrl.sv
src/aes_state_reg.sv
src/aes256_dec.sv
verif/tb_clk_gen.sv
verif/aes256_dec_tb.sv

//--- verif/aes256_dec_tb.sv
// aes-256 decryption core testbench
`timescale 1ns/1ns
`include "aes_dec_defines.svh"

module aes256_dec_tb;
    import aes_types_pkg::*;

    localparam int clk_period  = 40;
    localparam int num_tests   = 5;
    // one decryption takes about 300 cycles
    localparam int run_limit   = 400;
    localparam int watchdog_ns = num_tests * 400 * clk_period;

    // fips-197 aes-256 example with key 000102..1f
    localparam aes_block_t cipher_vec = 128'h8ea2b7ca516745bfeafc49904b496089;
    localparam aes_block_t plain_vec  = 128'h00112233445566778899aabbccddeeff;
    localparam aes_block_t other_vec  = 128'h000102030405060708090a0b0c0d0e0f;

    logic                          clk;
    logic                          resetn;
    logic                          in_valid;
    aes_block_t                    in_data;
    logic [`AES_KEY_ADDR_BITS-1:0] key_addr;
    aes_block_t                    key;
    logic                          out_valid;
    aes_block_t                    out_data;

    aes_block_t round_keys [0:`AES_NR];
    int         key_trace [$];
    int         err_count;
    int         test_errs;
    int         fail_tests;

    tb_clk_gen #(.period_ns(clk_period), .reset_cycles(4)) clk_i
    (
        .clk    (clk),
        .resetn (resetn)
    );

    aes256_dec dut_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .in_data   (in_data),
        .key_addr  (key_addr),
        .key       (key),
        .out_valid (out_valid),
        .out_data  (out_data)
    );

    // external key memory answering in the same cycle
    // round key n of the expansion sits at address n
    initial
    begin
        round_keys[0]  = 128'h000102030405060708090a0b0c0d0e0f;
        round_keys[1]  = 128'h101112131415161718191a1b1c1d1e1f;
        round_keys[2]  = 128'ha573c29fa176c498a97fce93a572c09c;
        round_keys[3]  = 128'h1651a8cd0244beda1a5da4c10640bade;
        round_keys[4]  = 128'hae87dff00ff11b68a68ed5fb03fc1567;
        round_keys[5]  = 128'h6de1f1486fa54f9275f8eb5373b8518d;
        round_keys[6]  = 128'hc656827fc9a799176f294cec6cd5598b;
        round_keys[7]  = 128'h3de23a75524775e727bf9eb45407cf39;
        round_keys[8]  = 128'h0bdc905fc27b0948ad5245a4c1871c2f;
        round_keys[9]  = 128'h45f5a66017b2d387300d4d33640a820a;
        round_keys[10] = 128'h7ccff71cbeb4fe5413e6bbf0d261a7df;
        round_keys[11] = 128'hf01afafee7a82979d7a5644ab3afe640;
        round_keys[12] = 128'h2541fe719bf500258813bbd55a721c0a;
        round_keys[13] = 128'h4e5a6699a9f24fe07e572baacdf8cdea;
        round_keys[14] = 128'h24fc79ccbf0979e9371ac23c6d68de36;
    end

    // address 15 is unused
    assign key = (key_addr <= `AES_NR) ? round_keys[key_addr] : '0;

    task automatic check_value(input string name, input logic [127:0] expected,
                               input logic [127:0] actual);
        if (actual !== expected)
        begin
            $display("error %s: expected %h, actual %h", name, expected, actual);
            err_count++;
        end
    endtask

    task automatic start_test();
        test_errs = err_count;
    endtask

    task automatic finish_test(input string name);
        if (err_count == test_errs)
        begin
            $display("%s: ok", name);
        end
        else
        begin
            $display("%s: fail, %0d errors", name, err_count - test_errs);
            fail_tests++;
        end
    endtask

    // pulse in_valid and wait for out_valid
    // key_addr traced every cycle
    // busy_cycle above zero sends a second strobe that many cycles in
    task automatic run_block(input string name, input aes_block_t ct, input int busy_cycle,
                             input aes_block_t busy_ct, output aes_block_t result);
        int   cycles;
        logic got;
        cycles = 0;
        got    = 1'b0;
        result = '0;
        key_trace.delete();
        @(negedge clk);
        in_data  = ct;
        in_valid = 1'b1;
        while (!got && cycles < run_limit)
        begin
            @(negedge clk);
            in_valid = 1'b0;
            key_trace.push_back(int'(key_addr));
            if (out_valid)
            begin
                got    = 1'b1;
                result = out_data;
            end
            else if (busy_cycle > 0 && cycles == busy_cycle)
            begin
                in_data  = busy_ct;
                in_valid = 1'b1;
            end
            cycles++;
        end
        if (!got)
        begin
            $display("%s: no out_valid pulse within %0d cycles", name, run_limit);
            err_count++;
        end
    endtask

    // idle cycles with out_valid low and out_data held
    task automatic hold_gap(input string name, input int cycles, input aes_block_t held);
        repeat (cycles)
        begin
            @(negedge clk);
            check_value({name, " out_valid"}, 128'(1'b0), 128'(out_valid));
            check_value({name, " out_data"}, held, out_data);
        end
    endtask

    task automatic test_reset_state();
        start_test();
        check_value("reset out_valid", 128'(1'b0), 128'(out_valid));
        check_value("reset out_data", '0, out_data);
        check_value("reset key_addr", 128'(`AES_NR), 128'(key_addr));
        finish_test("reset_state");
    endtask

    task automatic test_known_vector();
        aes_block_t res;
        start_test();
        run_block("known_vector", cipher_vec, 0, '0, res);
        check_value("known_vector", plain_vec, res);
        finish_test("known_vector");
    endtask

    task automatic test_key_order();
        aes_block_t res;
        int         next_addr;
        int         last_addr;
        start_test();
        run_block("key_order", cipher_vec, 0, '0, res);
        next_addr = `AES_NR;
        last_addr = `AES_NR;
        // each address may repeat
        // only a step of one down is allowed
        foreach (key_trace[i])
        begin
            if (key_trace[i] == next_addr)
            begin
                last_addr = next_addr;
                next_addr--;
            end
            else if (key_trace[i] != last_addr)
            begin
                check_value("key_order step", 128'(next_addr), 128'(key_trace[i]));
                break;
            end
        end
        check_value("key_order last", '0, 128'(last_addr));
        finish_test("key_order");
    endtask

    task automatic test_busy_strobe();
        aes_block_t res;
        start_test();
        run_block("busy_strobe", cipher_vec, 100, other_vec, res);
        check_value("busy_strobe", plain_vec, res);
        // a second run would move key_addr or pulse out_valid again
        repeat (40)
        begin
            @(negedge clk);
            check_value("busy_strobe out_valid", 128'(1'b0), 128'(out_valid));
            check_value("busy_strobe key_addr", 128'(`AES_NR), 128'(key_addr));
        end
        finish_test("busy_strobe");
    endtask

    task automatic test_back_to_back();
        aes_block_t res;
        int         gap;
        start_test();
        gap = 5 + ($urandom % 20);
        hold_gap("back_to_back gap before", gap, plain_vec);
        run_block("back_to_back 1", cipher_vec, 0, '0, res);
        check_value("back_to_back 1", plain_vec, res);
        gap = 5 + ($urandom % 20);
        hold_gap("back_to_back gap between", gap, plain_vec);
        run_block("back_to_back 2", cipher_vec, 0, '0, res);
        check_value("back_to_back 2", plain_vec, res);
        gap = 5 + ($urandom % 20);
        hold_gap("back_to_back gap after", gap, plain_vec);
        finish_test("back_to_back");
    endtask

    // ends a run that stalls
    initial
    begin
        #(watchdog_ns);
        $display("timeout: tests did not finish within %0d ns", watchdog_ns);
        $display("Result: FAILED");
        $finish;
    end

    initial
    begin
        void'($urandom(32'hf70));
        err_count  = 0;
        test_errs  = 0;
        fail_tests = 0;
        in_valid   = 1'b0;
        in_data    = '0;
        @(posedge resetn);
        @(negedge clk);
        test_reset_state();
        test_known_vector();
        test_key_order();
        test_busy_strobe();
        test_back_to_back();
        $display("tests run %0d, tests failed %0d, check errors %0d",
                 num_tests, fail_tests, err_count);
        if (err_count == 0)
        begin
            $display("Result: PASSED");
        end
        else
        begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- verif/tb_clk_gen.sv
// testbench clock and reset
`timescale 1ns/1ns

module tb_clk_gen
#(
    parameter int period_ns    = 40,
    parameter int reset_cycles = 4
)
(
    output logic clk,
    output logic resetn
);

    // free running clock
    initial
    begin
        clk = 1'b0;
        forever
        begin
            #(period_ns / 2);
            clk = ~clk;
        end
    end

    // reset held low, released on a falling edge
    initial
    begin
        resetn = 1'b0;
        repeat (reset_cycles) @(posedge clk);
        @(negedge clk);
        resetn = 1'b1;
    end

endmodule

//--- src/aes256_dec.sv
// aes-256 decryption core
`timescale 1ns/1ns
`include "aes_dec_defines.svh"

module aes256_dec
(
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          in_valid,
    input  aes_types_pkg::aes_block_t     in_data,
    output logic [`AES_KEY_ADDR_BITS-1:0] key_addr,
    input  aes_types_pkg::aes_block_t     key,
    output logic                          out_valid,
    output aes_types_pkg::aes_block_t     out_data
);

    // capture strobes from the sequencer
    logic load;
    logic ark;
    logic mix_cap;

    // sub bytes link and mix columns link
    aes_stage_if sub_if ();
    aes_stage_if mix_if ();

    dec_round_ctrl ctrl_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_valid  (in_valid),
        .key_addr  (key_addr),
        .load      (load),
        .ark       (ark),
        .mix_cap   (mix_cap),
        .out_valid (out_valid),
        .sub_if    (sub_if),
        .mix_if    (mix_if)
    );

    aes_state_reg state_i
    (
        .clk       (clk),
        .resetn    (resetn),
        .in_data   (in_data),
        .key       (key),
        .load      (load),
        .ark       (ark),
        .mix_cap   (mix_cap),
        .out_valid (out_valid),
        .out_data  (out_data),
        .sub_if    (sub_if),
        .mix_if    (mix_if)
    );

    inv_shift_sub_bytes sub_i
    (
        .clk    (clk),
        .resetn (resetn),
        .stg    (sub_if)
    );

    inv_mix_columns mix_i
    (
        .clk    (clk),
        .resetn (resetn),
        .stg    (mix_if)
    );

endmodule

//--- src/aes_state_reg.sv
// working block and output register
`timescale 1ns/1ns

module aes_state_reg
(
    input  logic                      clk,
    input  logic                      resetn,
    input  aes_types_pkg::aes_block_t in_data,
    input  aes_types_pkg::aes_block_t key,
    input  logic                      load,
    input  logic                      ark,
    input  logic                      mix_cap,
    input  logic                      out_valid,
    output aes_types_pkg::aes_block_t out_data,
    aes_stage_if.feed                 sub_if,
    aes_stage_if.feed                 mix_if
);
    import aes_types_pkg::*;

    aes_block_t work;
    aes_block_t out_q;

    // round key addition on load and ark
    // mix result taken as is
    always_ff @(posedge clk)
    begin
        if (load)
        begin
            work <= in_data ^ key;
        end
        else if (ark)
        begin
            work <= sub_if.blk_out ^ key;
        end
        else if (mix_cap)
        begin
            work <= mix_if.blk_out;
        end
    end

    // plaintext kept until the next completion
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            out_q <= '0;
        end
        else if (out_valid)
        begin
            out_q <= work;
        end
    end

    // final block already shown during the out_valid cycle
    assign out_data = out_valid ? work : out_q;

    // both stages read the same working block
    assign sub_if.blk_in = work;
    assign mix_if.blk_in = work;

endmodule

//--- src/dec_round_ctrl.sv
// decryption round sequencer
`timescale 1ns/1ns
`include "aes_dec_defines.svh"

module dec_round_ctrl
(
    input  logic                          clk,
    input  logic                          resetn,
    input  logic                          in_valid,
    output logic [`AES_KEY_ADDR_BITS-1:0] key_addr,
    output logic                          load,
    output logic                          ark,
    output logic                          mix_cap,
    output logic                          out_valid,
    aes_stage_if.master                   sub_if,
    aes_stage_if.master                   mix_if
);
    import aes_ctrl_pkg::*;

    dec_state_e state;
    dec_state_e state_nxt;
    round_t     round;
    logic       last_round;
    logic       sub_start;
    logic       mix_start;

    // round 14 skips mix columns
    assign last_round = (round == round_t'(`AES_NR));

    // keys are used in reverse, 14 first and 0 last
    assign key_addr = round_t'(`AES_NR) - round;

    // next state and capture strobes
    always_comb
    begin
        state_nxt = state;
        load      = 1'b0;
        ark       = 1'b0;
        mix_cap   = 1'b0;
        case (state)
            IDLE:
            begin
                // initial key add with key_addr at 14
                if (in_valid)
                begin
                    load      = 1'b1;
                    state_nxt = LOAD;
                end
            end
            LOAD:
            begin
                state_nxt = SUB;
            end
            SUB:
            begin
                if (sub_if.done)
                begin
                    state_nxt = ARK;
                end
            end
            ARK:
            begin
                ark       = 1'b1;
                state_nxt = last_round ? DONE : MIX;
            end
            MIX:
            begin
                if (mix_if.done)
                begin
                    mix_cap   = 1'b1;
                    state_nxt = SUB;
                end
            end
            DONE:
            begin
                state_nxt = IDLE;
            end
            default:
            begin
                state_nxt = IDLE;
            end
        endcase
    end

    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            state     <= IDLE;
            round     <= '0;
            sub_start <= 1'b0;
            mix_start <= 1'b0;
            out_valid <= 1'b0;
        end
        else
        begin
            state <= state_nxt;
            // start in the first cycle of a stage state
            // so the stage sees the block captured on entry
            sub_start <= (state_nxt == SUB) && (state != SUB);
            mix_start <= (state_nxt == MIX) && (state != MIX);
            out_valid <= (state_nxt == DONE);
            // round only moves outside SUB so the key stays put for ARK
            if (state == LOAD)
            begin
                round <= round_t'(1);
            end
            else if (mix_cap)
            begin
                round <= round + 1'b1;
            end
            else if (state == DONE)
            begin
                round <= '0;
            end
        end
    end

    assign sub_if.start = sub_start;
    assign mix_if.start = mix_start;

endmodule

//--- src/inv_mix_columns.sv
// inverse mix columns stage
`timescale 1ns/1ns
`include "aes_dec_defines.svh"

module inv_mix_columns
(
    input  logic       clk,
    input  logic       resetn,
    aes_stage_if.stage stg
);
    import aes_types_pkg::*;

    localparam int ncols = `AES_BLOCK_BITS / 32;

    aes_block_t mixed;
    aes_block_t blk_q;
    logic       done_q;

    // column times the inverse matrix
    // rows are 0e 0b 0d 09 rotated right once per row
    function automatic aes_col_t inv_mix_col(input aes_col_t col);
        aes_col_t res;
        res[0] = gf_mul14(col[0]) ^ gf_mul11(col[1]) ^ gf_mul13(col[2]) ^ gf_mul9(col[3]);
        res[1] = gf_mul9(col[0]) ^ gf_mul14(col[1]) ^ gf_mul11(col[2]) ^ gf_mul13(col[3]);
        res[2] = gf_mul13(col[0]) ^ gf_mul9(col[1]) ^ gf_mul14(col[2]) ^ gf_mul11(col[3]);
        res[3] = gf_mul11(col[0]) ^ gf_mul13(col[1]) ^ gf_mul9(col[2]) ^ gf_mul14(col[3]);
        return res;
    endfunction

    // all columns in parallel
    always_comb
    begin
        for (int c = 0; c < ncols; c++)
        begin
            mixed[4*c +: 4] = inv_mix_col(stg.blk_in[4*c +: 4]);
        end
    end

    always_ff @(posedge clk)
    begin
        if (stg.start)
        begin
            blk_q <= mixed;
        end
    end

    // result ready one cycle after start
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            done_q <= 1'b0;
        end
        else
        begin
            done_q <= stg.start;
        end
    end

    assign stg.blk_out = blk_q;
    assign stg.done    = done_q;

endmodule

//--- src/inv_shift_sub_bytes.sv
// inverse shift rows and sub bytes stage
`timescale 1ns/1ns
`include "aes_dec_defines.svh"

module inv_shift_sub_bytes
(
    input  logic       clk,
    input  logic       resetn,
    aes_stage_if.stage stg
);
    import aes_types_pkg::*;

    localparam int idx_bits = $clog2(`AES_NBYTES);
    localparam logic [idx_bits-1:0] last_idx = idx_bits'(`AES_NBYTES - 1);

    aes_block_t          blk_buf;
    aes_block_t          shifted;
    aes_byte_t           sbox_addr;
    aes_byte_t           sbox_data;
    logic                rd_busy;
    logic [idx_bits-1:0] rd_idx;
    logic                wr_en;
    logic [idx_bits-1:0] wr_idx;
    logic                done_q;

    // row r rotates right by r columns
    function automatic aes_block_t inv_shift_rows(input aes_block_t blk);
        aes_block_t res;
        for (int c = 0; c < 4; c++)
        begin
            for (int r = 0; r < 4; r++)
            begin
                res[4*c + r] = blk[4*((c - r + 4) % 4) + r];
            end
        end
        return res;
    endfunction

    assign shifted = inv_shift_rows(stg.blk_in);

    // byte 0 goes straight from the input on start
    // later bytes are read back from the buffer
    assign sbox_addr = stg.start ? shifted[0] : blk_buf[rd_idx];

    inv_sbox_rom sbox_i
    (
        .clk  (clk),
        .addr (sbox_addr),
        .data (sbox_data)
    );

    // read walk and write pointer, writes trail reads by the table latency
    always_ff @(posedge clk or negedge resetn)
    begin
        if (!resetn)
        begin
            rd_busy <= 1'b0;
            rd_idx  <= '0;
            wr_en   <= 1'b0;
            wr_idx  <= '0;
            done_q  <= 1'b0;
        end
        else
        begin
            wr_en  <= stg.start | rd_busy;
            wr_idx <= stg.start ? '0 : rd_idx;
            // last write lands on this edge
            done_q <= wr_en && (wr_idx == last_idx);
            if (stg.start)
            begin
                rd_busy <= 1'b1;
                rd_idx  <= idx_bits'(1);
            end
            else if (rd_busy)
            begin
                rd_idx <= rd_idx + 1'b1;
                if (rd_idx == last_idx)
                begin
                    rd_busy <= 1'b0;
                end
            end
        end
    end

    // shifted block in, then each slot overwritten by its substitute
    always_ff @(posedge clk)
    begin
        if (stg.start)
        begin
            blk_buf <= shifted;
        end
        else if (wr_en)
        begin
            blk_buf[wr_idx] <= sbox_data;
        end
    end

    assign stg.blk_out = blk_buf;
    assign stg.done    = done_q;

endmodule

//--- src/inv_sbox_rom.sv
// inverse s-box table
`timescale 1ns/1ns

module inv_sbox_rom
(
    input  logic                   clk,
    input  aes_types_pkg::aes_byte_t addr,
    output aes_types_pkg::aes_byte_t data
);
    import aes_types_pkg::*;

    // entry 0 leftmost, one row of 16 entries per line
    localparam logic [0:255][7:0] inv_sbox_tbl =
    {
        128'h52096ad53036a538bf40a39e81f3d7fb,
        128'h7ce339829b2fff87348e4344c4dee9cb,
        128'h547b9432a6c2233dee4c950b42fac34e,
        128'h082ea16628d924b2765ba2496d8bd125,
        128'h72f8f66486689816d4a45ccc5d65b692,
        128'h6c704850fdedb9da5e154657a78d9d84,
        128'h90d8ab008cbcd30af7e45805b8b34506,
        128'hd02c1e8fca3f0f02c1afbd0301138a6b,
        128'h3a9111414f67dcea97f2cfcef0b4e673,
        128'h96ac7422e7ad3585e2f937e81c75df6e,
        128'h47f11a711d29c5896fb7620eaa18be1b,
        128'hfc563e4bc6d279209adbc0fe78cd5af4,
        128'h1fdda8338807c731b11210592780ec5f,
        128'h60517fa919b54a0d2de57a9f93c99cef,
        128'ha0e03b4dae2af5b0c8ebbb3c83539961,
        128'h172b047eba77d626e169146355210c7d
    };

    // one cycle read latency
    aes_byte_t data_q;

    always_ff @(posedge clk)
    begin
        data_q <= inv_sbox_tbl[addr];
    end

    assign data = data_q;

endmodule

//--- src/aes_stage_if.sv
// transform stage interface
`timescale 1ns/1ns

interface aes_stage_if;
    import aes_types_pkg::*;

    // one-cycle request into the stage
    logic       start;
    // block sampled by the stage with start
    aes_block_t blk_in;
    // one-cycle completion from the stage
    logic       done;
    // stage result, held from done until the next start
    aes_block_t blk_out;

    // sequencer side
    modport master (output start, input done);

    // working register side
    modport feed (output blk_in, input blk_out);

    // transform stage side
    modport stage (input start, input blk_in, output done, output blk_out);

endinterface

//--- src/aes_ctrl_pkg.sv
// decryption sequencer types
`include "aes_dec_defines.svh"

package aes_ctrl_pkg;

    // sequencer states
    // LOAD waits one cycle after the initial key addition
    // SUB waits on the byte-serial stage
    // ARK adds the round key
    // MIX waits on inverse mix columns
    typedef enum logic [2:0]
    {
        IDLE,
        LOAD,
        SUB,
        ARK,
        MIX,
        DONE
    } dec_state_e;

    // round index, 0 for the initial key add up to 14
    typedef logic [`AES_KEY_ADDR_BITS-1:0] round_t;

endpackage

//--- src/aes_types_pkg.sv
// aes data types and gf arithmetic
`include "aes_dec_defines.svh"

package aes_types_pkg;

    // single state byte
    typedef logic [7:0] aes_byte_t;
    // one state column, row 0 in the top byte
    typedef logic [0:3][7:0] aes_col_t;
    // full block, byte 0 in bits 127:120
    typedef logic [0:`AES_NBYTES-1][7:0] aes_block_t;

    // multiply by x modulo the aes polynomial
    function automatic aes_byte_t gf_xtime(input aes_byte_t b);
        return {b[6:0], 1'b0} ^ (b[7] ? 8'h1b : 8'h00);
    endfunction

    function automatic aes_byte_t gf_mul9(input aes_byte_t b);
        return gf_xtime(gf_xtime(gf_xtime(b))) ^ b;
    endfunction

    function automatic aes_byte_t gf_mul11(input aes_byte_t b);
        return gf_xtime(gf_xtime(gf_xtime(b))) ^ gf_xtime(b) ^ b;
    endfunction

    function automatic aes_byte_t gf_mul13(input aes_byte_t b);
        return gf_xtime(gf_xtime(gf_xtime(b))) ^ gf_xtime(gf_xtime(b)) ^ b;
    endfunction

    // 14 = 8 + 4 + 2, no plain term
    function automatic aes_byte_t gf_mul14(input aes_byte_t b);
        return gf_xtime(gf_xtime(gf_xtime(b))) ^ gf_xtime(gf_xtime(b)) ^ gf_xtime(b);
    endfunction

endpackage

//--- src/aes_dec_defines.svh
// aes-256 decryption constants
`ifndef AES_DEC_DEFINES_SVH
`define AES_DEC_DEFINES_SVH

// number of cipher rounds for a 256-bit key
`define AES_NR 14

// block width in bits
`define AES_BLOCK_BITS 128

// bytes per block
`define AES_NBYTES 16

// round key address width, covers 0 to 14
`define AES_KEY_ADDR_BITS 4

`endif
